/* hw/div_cfg.svh */
/*
 * global word width of the divider, shared by every block
 * no module carries a width parameter, so change it here only
 * DIV_STEPS is one step per quotient bit of the widened word
 */
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand, quotient and remainder width
`define DIV_WORD_WIDTH 8

// the core works one bit wider than the word, hence one extra step
`define DIV_STEPS (`DIV_WORD_WIDTH + 1)

`endif

/* hw/div_pkg.sv */
/*
 * types shared by the two iterative units of the divider core
 * the state encoding matches across both units, the fourth code is unused
 */
package div_pkg;

    // iterative unit states, LOAD -> CALC -> DONE -> LOAD
    // 2'b01 is never reached
    typedef enum logic [1:0] {
        LOAD = 2'b00,
        CALC = 2'b10,
        DONE = 2'b11
    } div_state_e;

    // operation applied by a trial step
    typedef enum logic {
        ADD = 1'b0,
        SUB = 1'b1
    } div_addsub_e;

endpackage

/* hw/div_operand_if.sv */
/*
 * one accepted operand pair, operand stage to remainder unit
 * valid/ready stream, divisor_zero is precomputed by the source
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

interface div_operand_if;

    logic                       valid;
    logic                       ready;
    logic [`DIV_WORD_WIDTH-1:0] dividend;
    logic [`DIV_WORD_WIDTH-1:0] divisor;
    // divisor is all zeros
    logic                       divisor_zero;

    modport source (output valid, dividend, divisor, divisor_zero, input ready);

    modport sink (input valid, dividend, divisor, divisor_zero, output ready);

endinterface

/* hw/div_result_if.sv */
/*
 * remainder result, remainder unit to result stage
 * valid/ready stream, remainder is already truncated to the word width
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

interface div_result_if;

    logic                       valid;
    logic                       ready;
    // signed remainder, takes the dividend's sign
    logic [`DIV_WORD_WIDTH-1:0] remainder;
    logic                       div_by_zero;

    modport source (output valid, remainder, div_by_zero, input ready);

    modport sink (input valid, remainder, div_by_zero, output ready);

endinterface

/* hw/div_operand_stage.sv */
/*
 * one-entry operand register in front of the divider core
 * operand_in_ready looks through to the core's ready, so a full entry that
 * drains this cycle can be refilled on the same edge
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_operand_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       operand_in_valid,
    output logic                       operand_in_ready,
    input  logic [`DIV_WORD_WIDTH-1:0] dividend,
    input  logic [`DIV_WORD_WIDTH-1:0] divisor,
    div_operand_if.source              operand
);

    logic full;
    logic load;

    // empty, or emptying into the core this cycle
    assign operand_in_ready = !full || operand.ready;
    assign load             = operand_in_valid && operand_in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            full <= 1'b0;
        end else if (operand_in_ready) begin
            full <= operand_in_valid;
        end
    end

    // payload only, qualified by full
    always_ff @(posedge clock) begin
        if (load) begin
            operand.dividend     <= dividend;
            operand.divisor      <= divisor;
            // zero test done once here, later stages only see the flag
            operand.divisor_zero <= (divisor == '0);
        end
    end

    assign operand.valid = full;

    // a pair offered from upstream must not change before it is taken
    a_operand_hold: assert property (@(posedge clock) disable iff (reset)
        operand_in_valid && !operand_in_ready |=> operand_in_valid
            && $stable(dividend) && $stable(divisor));

endmodule

/* hw/remainder_integer_signed.sv */
/*
 * signed remainder by truncating long division, one trial step per cycle
 * runs in lockstep with quotient_integer_signed, both load on the same edge
 * a zero divisor makes every trial succeed, remainder is then the dividend
 * no early termination, every division takes DIV_STEPS steps
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module remainder_integer_signed
    import div_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    div_operand_if.sink operand,
    output logic        quot_input_valid,
    input  logic        quot_input_ready,
    output logic        dividend_sign,
    output logic        divisor_sign,
    output logic        step_valid,
    input  logic        step_ready,
    output logic        step_ok,
    div_result_if.source result
);

    localparam int W       = `DIV_WORD_WIDTH;
    localparam int STEPS   = `DIV_STEPS;
    // one extra bit so the most negative dividend needs no special case
    localparam int LONG_W  = W + 1;
    // divisor pre-shifted by the top step index
    localparam int DIVS_W  = 2 * W + 1;
    localparam int TRIAL_W = DIVS_W + 1;
    localparam int CNT_W   = $clog2(STEPS);

    div_state_e          state;
    div_state_e          state_next;
    div_addsub_e         addsub;
    logic [CNT_W-1:0]    step_count;
    logic [LONG_W-1:0]   remainder_q;
    logic [DIVS_W-1:0]   divisor_shift_q;
    logic                dividend_sign_q;
    logic                div_by_zero_q;
    logic [TRIAL_W-1:0]  rem_ext;
    logic [TRIAL_W-1:0]  div_ext;
    logic [TRIAL_W-1:0]  trial;
    logic                load;
    logic                step;
    logic                unload;

    // signs go straight to the quotient unit, sampled there on load
    assign dividend_sign    = operand.dividend[W-1];
    assign divisor_sign     = operand.divisor[W-1];

    // take an operand only together with the quotient unit
    assign quot_input_valid = (state == LOAD) && operand.valid;
    assign operand.ready    = (state == LOAD) && quot_input_ready;

    assign step_valid       = (state == CALC);
    assign result.valid     = (state == DONE);

    assign load   = operand.valid && operand.ready;
    assign step   = step_valid && step_ready;
    assign unload = result.valid && result.ready;

    // move toward zero: subtract when signs match, else add
    // shifted divisor keeps the divisor's sign in its msb
    assign addsub  = (dividend_sign_q == divisor_shift_q[DIVS_W-1]) ? SUB : ADD;
    assign rem_ext = {{(TRIAL_W - LONG_W){remainder_q[LONG_W-1]}}, remainder_q};
    assign div_ext = {divisor_shift_q[DIVS_W-1], divisor_shift_q};
    assign trial   = (addsub == SUB) ? rem_ext - div_ext : rem_ext + div_ext;

    // trial is kept if it did not cross zero
    assign step_ok = (trial == '0) || (trial[TRIAL_W-1] == dividend_sign_q);

    always_comb begin
        state_next = state;
        case (state)
            LOAD: if (load) state_next = CALC;
            CALC: if (step && (step_count == '0)) state_next = DONE;
            DONE: if (unload) state_next = LOAD;
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= LOAD;
            step_count <= '0;
        end else begin
            state <= state_next;
            if (load) begin
                step_count <= CNT_W'(STEPS - 1);
            end else if (step) begin
                step_count <= step_count - 1'b1;
            end
        end
    end

    // datapath, no reset
    always_ff @(posedge clock) begin
        if (load) begin
            remainder_q     <= {operand.dividend[W-1], operand.dividend};
            divisor_shift_q <= {operand.divisor[W-1], operand.divisor, {W{1'b0}}};
            dividend_sign_q <= operand.dividend[W-1];
            div_by_zero_q   <= operand.divisor_zero;
        end else if (step) begin
            if (step_ok) begin
                remainder_q <= trial[LONG_W-1:0];
            end
            // arithmetic shift, low bits are zero so nothing is lost
            divisor_shift_q <= {divisor_shift_q[DIVS_W-1], divisor_shift_q[DIVS_W-1:1]};
        end
    end

    // remainder magnitude never exceeds the dividend, word width is enough
    assign result.remainder   = remainder_q[W-1:0];
    assign result.div_by_zero = div_by_zero_q;

    // quotient unit must accept a step every CALC cycle, or the units drift
    a_step_window: assert property (@(posedge clock) disable iff (reset)
        $rose(step_valid) |-> (step_valid && step_ready && (state == CALC)) [*STEPS]
            ##1 (!step_valid && (state == DONE)));

endmodule

/* hw/quotient_integer_signed.sv */
/*
 * signed quotient by truncating long division, driven step by step by
 * remainder_integer_signed through step_valid/step_ready/step_ok
 * works one bit wider than the word, result is truncated on output
 * so -MIN/-1 wraps back to MIN
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module quotient_integer_signed
    import div_pkg::*;
(
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       input_valid,
    output logic                       input_ready,
    input  logic                       dividend_sign,
    input  logic                       divisor_sign,
    output logic                       output_valid,
    input  logic                       output_ready,
    output logic [`DIV_WORD_WIDTH-1:0] quotient,
    input  logic                       step_valid,
    output logic                       step_ready,
    input  logic                       step_ok
);

    localparam int W      = `DIV_WORD_WIDTH;
    localparam int LONG_W = W + 1;

    div_state_e        state;
    div_state_e        state_next;
    div_addsub_e       addsub;
    logic              dividend_sign_q;
    logic              divisor_sign_q;
    logic [LONG_W-1:0] quotient_q;
    logic [LONG_W-1:0] quotient_next;
    // one-hot weight of the current step
    logic [LONG_W-1:0] increment;
    logic              load;
    logic              step;
    logic              unload;
    logic              last_step;

    assign input_ready  = (state == LOAD);
    assign output_valid = (state == DONE);
    // the adder is single cycle, so a step is taken every CALC cycle
    assign step_ready   = (state == CALC);

    assign load      = input_valid && input_ready;
    assign step      = step_valid && step_ready;
    assign unload    = output_valid && output_ready;
    // weight has reached bit zero
    assign last_step = step && increment[0];

    // matching signs give a positive quotient
    assign addsub = (dividend_sign_q == divisor_sign_q) ? ADD : SUB;

    assign quotient_next = (addsub == ADD) ? quotient_q + increment
                                           : quotient_q - increment;

    always_comb begin
        state_next = state;
        case (state)
            LOAD: if (load) state_next = CALC;
            CALC: if (last_step) state_next = DONE;
            DONE: if (unload) state_next = LOAD;
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= LOAD;
            increment <= '0;
        end else begin
            state <= state_next;
            if (load) begin
                // start at the top step bit
                increment <= {1'b1, {W{1'b0}}};
            end else if (step) begin
                increment <= increment >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            dividend_sign_q <= dividend_sign;
            divisor_sign_q  <= divisor_sign;
            quotient_q      <= '0;
        end else if (step && step_ok) begin
            quotient_q <= quotient_next;
        end
    end

    // drop the guard bit
    assign quotient = quotient_q[W-1:0];

    // every CALC cycle gets a step from the remainder unit, one weight bit set
    a_increment_onehot: assert property (@(posedge clock) disable iff (reset)
        (state == CALC) |-> step_valid && $onehot(increment));

endmodule

/* hw/div_result_stage.sv */
/*
 * join of the quotient and remainder streams into one output register
 * both inputs transfer on the same edge, never one without the other
 * the register holds its word while out_ready is low
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module div_result_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       quot_valid,
    output logic                       quot_ready,
    input  logic [`DIV_WORD_WIDTH-1:0] quotient,
    div_result_if.sink                 rem,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`DIV_WORD_WIDTH-1:0] out_quotient,
    output logic [`DIV_WORD_WIDTH-1:0] out_remainder,
    output logic                       out_div_by_zero
);

    logic can_take;
    logic both_valid;
    logic load;

    // register empty or draining this cycle
    assign can_take   = !out_valid || out_ready;
    assign both_valid = quot_valid && rem.valid;
    assign load       = both_valid && can_take;

    // same ready to both sides keeps them in step
    assign quot_ready = load;
    assign rem.ready  = load;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (can_take) begin
            out_valid <= both_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_quotient    <= quotient;
            out_remainder   <= rem.remainder;
            out_div_by_zero <= rem.div_by_zero;
        end
    end

    // the two core units finish and unload together
    a_join_lockstep: assert property (@(posedge clock) disable iff (reset)
        quot_valid == rem.valid);

    // a waiting result pair stays valid and unchanged until the join takes it
    a_join_hold: assert property (@(posedge clock) disable iff (reset)
        both_valid && !load |=> both_valid && $stable(quotient)
            && $stable(rem.remainder) && $stable(rem.div_by_zero));

endmodule

/* hw/divider_integer_signed.sv */
/*
 * signed truncating divider, operand stage, iterative core, result stage
 * up to three divisions in flight, results leave in order
 * divide by zero sets out_div_by_zero, quotient -1 or +1, remainder = dividend
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module divider_integer_signed (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`DIV_WORD_WIDTH-1:0] in_dividend,
    input  logic [`DIV_WORD_WIDTH-1:0] in_divisor,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`DIV_WORD_WIDTH-1:0] out_quotient,
    output logic [`DIV_WORD_WIDTH-1:0] out_remainder,
    output logic                       out_div_by_zero
);

    // operand pair into the core, remainder result out of it
    div_operand_if operand_bus ();
    div_result_if  result_bus ();

    // remainder unit to quotient unit load handshake
    logic                       quot_input_valid;
    logic                       quot_input_ready;
    logic                       dividend_sign;
    logic                       divisor_sign;
    // per-step control link
    logic                       step_valid;
    logic                       step_ready;
    logic                       step_ok;
    // quotient stream into the join
    logic                       quot_valid;
    logic                       quot_ready;
    logic [`DIV_WORD_WIDTH-1:0] quotient;

    div_operand_stage u_operand_stage (
        .clock            (clock),
        .reset            (reset),
        .operand_in_valid (in_valid),
        .operand_in_ready (in_ready),
        .dividend         (in_dividend),
        .divisor          (in_divisor),
        .operand          (operand_bus.source)
    );

    remainder_integer_signed u_remainder (
        .clock            (clock),
        .reset            (reset),
        .operand          (operand_bus.sink),
        .quot_input_valid (quot_input_valid),
        .quot_input_ready (quot_input_ready),
        .dividend_sign    (dividend_sign),
        .divisor_sign     (divisor_sign),
        .step_valid       (step_valid),
        .step_ready       (step_ready),
        .step_ok          (step_ok),
        .result           (result_bus.source)
    );

    quotient_integer_signed u_quotient (
        .clock         (clock),
        .reset         (reset),
        .input_valid   (quot_input_valid),
        .input_ready   (quot_input_ready),
        .dividend_sign (dividend_sign),
        .divisor_sign  (divisor_sign),
        .output_valid  (quot_valid),
        .output_ready  (quot_ready),
        .quotient      (quotient),
        .step_valid    (step_valid),
        .step_ready    (step_ready),
        .step_ok       (step_ok)
    );

    div_result_stage u_result_stage (
        .clock           (clock),
        .reset           (reset),
        .quot_valid      (quot_valid),
        .quot_ready      (quot_ready),
        .quotient        (quotient),
        .rem             (result_bus.sink),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_quotient    (out_quotient),
        .out_remainder   (out_remainder),
        .out_div_by_zero (out_div_by_zero)
    );

endmodule

/* dv/tb_divider_integer_signed.sv */
/*
 * testbench for the signed divider, table rows first, then random rows
 * inputs and out_ready change on the falling edge, outputs are read there too
 * table values assume two's complement at DIV_WORD_WIDTH bits
 * the run stops at the first mismatch or when the cycle limit is reached
 */
`timescale 1ns/1ps
`include "div_cfg.svh"

module tb_divider_integer_signed;

    localparam int W           = `DIV_WORD_WIDTH;
    localparam int MIN_VAL     = -(1 << (W - 1));
    localparam int MAX_VAL     = (1 << (W - 1)) - 1;
    localparam int RANDOM_ROWS = 48;
    // idle cycles after the last result, nothing more may come out
    localparam int DRAIN       = 2 * (`DIV_STEPS + 3);

    typedef struct packed {
        logic [W-1:0] dividend;
        logic [W-1:0] divisor;
        logic [W-1:0] quotient;
        logic [W-1:0] remainder;
        logic         div_by_zero;
    } row_t;

    logic         clock;
    logic         reset;
    logic         in_valid;
    logic         in_ready;
    logic [W-1:0] in_dividend;
    logic [W-1:0] in_divisor;
    logic         out_valid;
    logic         out_ready;
    logic [W-1:0] out_quotient;
    logic [W-1:0] out_remainder;
    logic         out_div_by_zero;

    row_t rows[$];
    // rows accepted by the DUT, oldest first
    row_t pending[$];
    int   table_count;
    int   received;
    int   cycle_count;
    int   cycle_limit;
    // in_ready seen low during the random section
    logic saw_full;

    divider_integer_signed u_divider_integer_signed (
        .clock           (clock),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_dividend     (in_dividend),
        .in_divisor      (in_divisor),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_quotient    (out_quotient),
        .out_remainder   (out_remainder),
        .out_div_by_zero (out_div_by_zero)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [W-1:0] expected,
                               input logic [W-1:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    // values are plain ints, cut to the word width here
    task automatic add_row(input int dividend, input int divisor, input int quotient,
                           input int remainder, input logic div_by_zero);
        row_t r;
        r.dividend    = dividend[W-1:0];
        r.divisor     = divisor[W-1:0];
        r.quotient    = quotient[W-1:0];
        r.remainder   = remainder[W-1:0];
        r.div_by_zero = div_by_zero;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // truncation toward zero, remainder follows the dividend
        add_row(22, 7, 3, 1, 1'b0);
        add_row(-22, 7, -3, -1, 1'b0);
        add_row(22, -7, -3, 1, 1'b0);
        add_row(-22, -7, 3, -1, 1'b0);
        // magnitude of dividend below divisor
        add_row(5, 9, 0, 5, 1'b0);
        add_row(-5, 9, 0, -5, 1'b0);
        add_row(5, -9, 0, 5, 1'b0);
        add_row(-5, -9, 0, -5, 1'b0);
        // zero divisor, every trial step succeeds
        add_row(0, 0, -1, 0, 1'b1);
        add_row(37, 0, -1, 37, 1'b1);
        add_row(-37, 0, 1, -37, 1'b1);
        // extremes, MIN/-1 wraps back to MIN
        add_row(MIN_VAL, -1, MIN_VAL, 0, 1'b0);
        add_row(MIN_VAL, 1, MIN_VAL, 0, 1'b0);
        add_row(MAX_VAL, MIN_VAL, 0, MAX_VAL, 1'b0);
        add_row(MIN_VAL, MIN_VAL, 1, 0, 1'b0);
        add_row(MAX_VAL, 1, MAX_VAL, 0, 1'b0);
        add_row(-1, MAX_VAL, 0, -1, 1'b0);
        add_row(MIN_VAL, MAX_VAL, -1, -1, 1'b0);
        add_row(MIN_VAL, 0, 1, MIN_VAL, 1'b1);
        add_row(0, -5, 0, 0, 1'b0);
        table_count = rows.size();
    endtask

    task automatic add_random_rows();
        logic signed [W-1:0] dividend;
        logic signed [W-1:0] divisor;
        int                  a;
        int                  b;
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            dividend = W'($urandom);
            // roughly one row in eight divides by zero
            if ($urandom % 8 == 0) begin
                divisor = '0;
            end else begin
                divisor = W'($urandom);
            end
            a = dividend;
            b = divisor;
            if (b == 0) begin
                add_row(a, 0, (a < 0) ? 1 : -1, a, 1'b1);
            end else begin
                add_row(a, b, a / b, a % b, 1'b0);
            end
        end
    endtask

    // streams rows back to back, in_ready does not depend on in_valid
    task automatic drive_rows();
        int idx;
        idx = 0;
        while (idx < rows.size()) begin
            @(negedge clock);
            in_valid    = 1'b1;
            in_dividend = rows[idx].dividend;
            in_divisor  = rows[idx].divisor;
            if (!in_ready && idx >= table_count) begin
                saw_full = 1'b1;
            end
            if (in_ready) begin
                pending.push_back(rows[idx]);
                idx++;
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    // out_ready held high for the table, random afterwards
    task automatic collect_results();
        row_t expected;
        while (received < rows.size()) begin
            @(negedge clock);
            if (received < table_count) begin
                out_ready = 1'b1;
            end else begin
                out_ready = $urandom % 2;
            end
            if (out_valid && out_ready) begin
                assert (pending.size() > 0) else
                    fail_run("result arrived with no division outstanding");
                expected = pending.pop_front();
                check_value("out_quotient", expected.quotient, out_quotient);
                check_value("out_remainder", expected.remainder, out_remainder);
                check_value("out_div_by_zero", W'(expected.div_by_zero), W'(out_div_by_zero));
                received++;
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            assert (cycle_limit == 0 || cycle_count < cycle_limit) else
                fail_run($sformatf("timeout, outputs stopped arriving after %0d cycles",
                                   cycle_count));
        end
    end

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_dividend = '0;
        in_divisor  = '0;
        out_ready   = 1'b0;
        received    = 0;
        saw_full    = 1'b0;
        cycle_limit = 0;
        void'($urandom(32'ha28d_0b9c));

        build_table();
        add_random_rows();
        // each row well under four times an isolated division
        cycle_limit = rows.size() * (`DIV_STEPS + 3) * 4 + DRAIN + 100;

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (out_valid === 1'b0) else fail_run("out_valid is high right after reset");
        assert (in_ready === 1'b1) else fail_run("in_ready is low right after reset");

        fork
            drive_rows();
            collect_results();
        join

        // no repeated or stray result once everything is checked
        repeat (DRAIN) begin
            @(negedge clock);
            out_ready = 1'b1;
            assert (out_valid === 1'b0) else
                fail_run("extra result appeared after all rows were checked");
        end

        assert (saw_full) else fail_run("in_ready never fell while the pipeline was full");

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
hw/div_pkg.sv
hw/div_operand_if.sv
hw/div_result_if.sv
hw/div_operand_stage.sv
hw/remainder_integer_signed.sv
hw/quotient_integer_signed.sv
hw/div_result_stage.sv
hw/divider_integer_signed.sv
dv/tb_divider_integer_signed.sv
